//--- dsp_core.f
hdl/dsp_core_pkg.sv
hdl/apb_command_port.sv
hdl/block_decode.sv
hdl/madd_execute.sv
hdl/channel_commit.sv
hdl/dsp_core.sv
tests/dsp_core_tb.sv

//--- Makefile
TOP = dsp_core_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f dsp_core.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f dsp_core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Test passed" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/dsp_core_tb.sv
`timescale 1ns/1ps

module dsp_core_tb;

	localparam int n_blocks = 16;
	localparam int n_channels = 16;
	localparam int n_ticks = 28; // 3 + 21 + 4 over the run tests.
	localparam int timeout_cycles = n_ticks * (dsp_core_pkg::block_cycles * n_blocks + 10) + 200;

	logic clk;
	logic reset;
	logic psel, penable, pwrite;
	logic [dsp_core_pkg::paddr_width - 1 : 0] paddr;
	logic [31 : 0] pwdata;
	logic [31 : 0] prdata;
	logic pready, pslverr;
	logic tick;
	dsp_core_pkg::sample_t sample_in;
	dsp_core_pkg::sample_t sample_out;
	logic busy;

	int seed = 32'h31b3_a428;
	int checks = 0;
	int errors = 0;
	int test_start_errors;
	int cycle_count;

	dsp_core #(.n_blocks(n_blocks), .n_channels(n_channels)) dsp_core_i (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.tick(tick), .sample_in(sample_in), .sample_out(sample_out), .busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: DUT still busy after %0d cycles", timeout_cycles);
		$display("Test failed");
		$finish;
	end

	//////////////////////////////
	// Compare tasks.
	task automatic check_sample(input string name, input dsp_core_pkg::sample_t got,
		input dsp_core_pkg::sample_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error at %0t: %s is %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	task automatic check_word(input string name, input logic [31 : 0] got,
		input logic [31 : 0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, expected);
		end
	endtask

	//////////////////////////////
	// Bus and tick drivers, entered and left on a falling edge.
	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic apb_write(input logic [15 : 0] addr, input logic [31 : 0] data,
		output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		err = pslverr;
		check_bit("pready", pready, 1'b1); // Zero wait states.
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input logic [15 : 0] addr, output logic [31 : 0] data,
		output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		data = prdata;
		err = pslverr;
		check_bit("pready", pready, 1'b1);
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_checked(input logic [15 : 0] addr, input logic [31 : 0] data);
		logic err;
		apb_write(addr, data, err);
		check_bit("pslverr", err, 1'b0);
	endtask

	task automatic run_tick(input dsp_core_pkg::sample_t value);
		tick = 1'b1;
		sample_in = value;
		@(negedge clk);
		tick = 1'b0;
		while (busy)
			@(negedge clk);
	endtask

	function automatic logic [15 : 0] instr_addr(input int blk);
		return dsp_core_pkg::instr_base + 16'(4 * blk);
	endfunction

	function automatic logic [15 : 0] reg_addr(input int blk, input int sel);
		return dsp_core_pkg::reg_base + 16'(8 * blk + 4 * sel);
	endfunction

	// reg_sel bits 0, 1, 2 route a, b, c to block registers.
	function automatic dsp_core_pkg::instr_t make_instr(input int dest, input int src_a,
		input int src_b, input int src_c, input logic [2 : 0] reg_sel, input int shift,
		input logic sat_dis);
		dsp_core_pkg::instr_t w;
		w = '0;
		w[dsp_core_pkg::instr_valid_bit] = 1'b1;
		w[dsp_core_pkg::dest_lsb +: 4] = dest[3 : 0];
		w[dsp_core_pkg::src_a_lsb +: 4] = src_a[3 : 0];
		w[dsp_core_pkg::src_b_lsb +: 4] = src_b[3 : 0];
		w[dsp_core_pkg::src_c_lsb +: 4] = src_c[3 : 0];
		w[dsp_core_pkg::src_a_reg_bit] = reg_sel[0];
		w[dsp_core_pkg::src_b_reg_bit] = reg_sel[1];
		w[dsp_core_pkg::src_c_reg_bit] = reg_sel[2];
		w[dsp_core_pkg::shift_lsb +: 5] = shift[4 : 0];
		w[dsp_core_pkg::sat_disable_bit] = sat_dis;
		return w;
	endfunction

	// Reference multiply-add on 64-bit integers.
	function automatic dsp_core_pkg::sample_t madd_model(input dsp_core_pkg::sample_t a,
		input dsp_core_pkg::sample_t b, input dsp_core_pkg::sample_t c, input int shift,
		input logic sat_dis);
		longint full;
		full = longint'(a) * longint'(b);
		full = full >>> shift;
		full = full + longint'(c);
		if (sat_dis)
			return dsp_core_pkg::sample_t'(full[15 : 0]);
		if (full > 32767)
			return 16'sh7fff;
		if (full < -32768)
			return 16'sh8000;
		return dsp_core_pkg::sample_t'(full[15 : 0]);
	endfunction

	task automatic end_test(input string name);
		$display("[%s] finished with %0d errors", name, errors - test_start_errors);
	endtask

	//////////////////////////////
	// Directed tests.
	task automatic after_reset_test();
		logic [31 : 0] data;
		logic err;
		test_start_errors = errors;
		check_bit("busy", busy, 1'b0);
		check_sample("sample_out", sample_out, 16'sd0);
		apb_read(dsp_core_pkg::status_addr, data, err);
		check_word("prdata", data, 32'd0);
		check_bit("pslverr", err, 1'b0);
		end_test("after_reset");
	endtask

	task automatic block_count_test();
		logic [31 : 0] data;
		logic err;
		test_start_errors = errors;
		write_checked(instr_addr(2), 32'h0);
		write_checked(instr_addr(0), 32'h0);
		apb_read(dsp_core_pkg::status_addr, data, err);
		check_word("prdata", data, 32'd3);
		check_bit("pslverr", err, 1'b0);
		apb_read(16'h3000, data, err);
		check_bit("pslverr", err, 1'b1);
		apb_write(dsp_core_pkg::status_addr, 32'd7, err);
		check_bit("pslverr", err, 1'b1);
		end_test("block_count");
	endtask

	task automatic pass_through_test();
		dsp_core_pkg::sample_t s [3];
		test_start_errors = errors;
		apply_reset();
		write_checked(reg_addr(0, 0), 32'd1);
		write_checked(reg_addr(0, 1), 32'd0);
		write_checked(instr_addr(0), make_instr(15, 0, 0, 1, 3'b110, 0, 1'b0));
		for (int i = 0; i < 3; i++) begin
			s[i] = dsp_core_pkg::sample_t'($random(seed));
			run_tick(s[i]);
			if (i > 0)
				check_sample("sample_out", sample_out, madd_model(s[i - 1], 1, 0, 0, 1'b0));
		end
		end_test("pass_through");
	endtask

	task automatic random_madd_test();
		dsp_core_pkg::sample_t s [21];
		dsp_core_pkg::sample_t reg0, reg1;
		int r;
		int shift;
		test_start_errors = errors;
		apply_reset();
		r = $random(seed);
		reg0 = dsp_core_pkg::sample_t'(16'h4000 | 16'(r[13 : 0])); // Large gain to force clamps.
		reg1 = dsp_core_pkg::sample_t'($random(seed));
		shift = $random(seed) & 7;
		write_checked(reg_addr(0, 0), 32'(reg0));
		write_checked(reg_addr(0, 1), 32'(reg1));
		write_checked(instr_addr(0), make_instr(15, 0, 0, 1, 3'b110, shift, 1'b0));
		s[0] = dsp_core_pkg::sample_max;
		s[1] = dsp_core_pkg::sample_min;
		for (int i = 2; i < 21; i++)
			s[i] = dsp_core_pkg::sample_t'($random(seed));
		for (int i = 0; i < 21; i++) begin
			run_tick(s[i]);
			if (i > 0)
				check_sample("sample_out", sample_out,
					madd_model(s[i - 1], reg0, reg1, shift, 1'b0));
		end
		end_test("random_madd");
	endtask

	task automatic chain_test();
		dsp_core_pkg::sample_t s [4];
		dsp_core_pkg::sample_t mid;
		test_start_errors = errors;
		apply_reset();
		write_checked(reg_addr(0, 0), 32'd3);
		write_checked(reg_addr(0, 1), 32'd100);
		write_checked(reg_addr(2, 0), 32'd25000);
		write_checked(reg_addr(2, 1), 32'hffff_fff9); // -7
		write_checked(instr_addr(0), make_instr(3, 0, 0, 1, 3'b110, 0, 1'b0));
		write_checked(instr_addr(1), 32'h0123_4563); // Nop aimed at channel 3.
		write_checked(instr_addr(2), make_instr(15, 3, 0, 1, 3'b110, 2, 1'b1));
		for (int i = 0; i < 4; i++) begin
			s[i] = dsp_core_pkg::sample_t'($random(seed));
			run_tick(s[i]);
			if (i > 0) begin
				mid = madd_model(s[i - 1], 3, 100, 0, 1'b0);
				check_sample("sample_out", sample_out, madd_model(mid, 25000, -7, 2, 1'b1));
			end
		end
		end_test("chain_nop_wrap");
	endtask

	initial begin
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		tick = 1'b0;
		sample_in = '0;
		apply_reset();
		after_reset_test();
		block_count_test();
		pass_through_test();
		random_madd_test();
		chain_test();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- hdl/dsp_core.sv
`timescale 1ns/1ps

module dsp_core #(
	parameter int n_blocks = 16,
	parameter int n_channels = 16
) (
	input logic clk,
	input logic reset,

	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [dsp_core_pkg::paddr_width - 1 : 0] paddr,
	input logic [31 : 0] pwdata,
	output logic [31 : 0] prdata,
	output logic pready,
	output logic pslverr,

	input logic tick,
	input dsp_core_pkg::sample_t sample_in,
	output dsp_core_pkg::sample_t sample_out,
	output logic busy
);

	localparam int block_w = $clog2(n_blocks);
	localparam int count_w = $clog2(n_blocks + 1);

	logic instr_write;
	logic [block_w - 1 : 0] instr_write_addr;
	dsp_core_pkg::instr_t instr_write_data;
	logic reg_write;
	logic [block_w - 1 : 0] reg_write_block;
	logic reg_write_sel;
	dsp_core_pkg::sample_t reg_write_data;
	logic [count_w - 1 : 0] n_blocks_running;

	logic [dsp_core_pkg::ch_addr_width - 1 : 0] src_a_addr, src_b_addr, src_c_addr;
	dsp_core_pkg::sample_t ch_a, ch_b, ch_c;

	logic issue_valid;
	dsp_core_pkg::sample_t arg_a, arg_b, arg_c;
	logic [dsp_core_pkg::shift_width - 1 : 0] shift;
	logic sat_disable;
	logic [dsp_core_pkg::ch_addr_width - 1 : 0] dest;

	logic result_valid;
	dsp_core_pkg::sample_t result;
	logic [dsp_core_pkg::ch_addr_width - 1 : 0] result_dest;
	logic commit_done;

	apb_command_port #(.n_blocks(n_blocks)) command_port_i (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr),
		.instr_write(instr_write),
		.instr_write_addr(instr_write_addr),
		.instr_write_data(instr_write_data),
		.reg_write(reg_write),
		.reg_write_block(reg_write_block),
		.reg_write_sel(reg_write_sel),
		.reg_write_data(reg_write_data),
		.n_blocks_running(n_blocks_running)
	);

	block_decode #(.n_blocks(n_blocks), .n_channels(n_channels)) decode_i (
		.clk(clk), .reset(reset), .tick(tick),
		.instr_write(instr_write),
		.instr_write_addr(instr_write_addr),
		.instr_write_data(instr_write_data),
		.reg_write(reg_write),
		.reg_write_block(reg_write_block),
		.reg_write_sel(reg_write_sel),
		.reg_write_data(reg_write_data),
		.n_blocks_running(n_blocks_running),
		.busy(busy),
		.src_a_addr(src_a_addr), .src_b_addr(src_b_addr), .src_c_addr(src_c_addr),
		.ch_a(ch_a), .ch_b(ch_b), .ch_c(ch_c),
		.issue_valid(issue_valid),
		.arg_a(arg_a), .arg_b(arg_b), .arg_c(arg_c),
		.shift(shift), .sat_disable(sat_disable), .dest(dest),
		.commit_done(commit_done)
	);

	madd_execute execute_i (
		.clk(clk), .reset(reset),
		.issue_valid(issue_valid),
		.arg_a(arg_a), .arg_b(arg_b), .arg_c(arg_c),
		.shift(shift), .sat_disable(sat_disable), .dest(dest),
		.result_valid(result_valid), .result(result), .dest_out(result_dest)
	);

	channel_commit #(.n_channels(n_channels)) commit_i (
		.clk(clk), .reset(reset), .tick(tick), .busy(busy),
		.sample_in(sample_in), .sample_out(sample_out),
		.src_a_addr(src_a_addr), .src_b_addr(src_b_addr), .src_c_addr(src_c_addr),
		.ch_a(ch_a), .ch_b(ch_b), .ch_c(ch_c),
		.result_valid(result_valid), .result(result), .dest(result_dest),
		.commit_done(commit_done)
	);

endmodule

//--- hdl/channel_commit.sv
`timescale 1ns/1ps

module channel_commit #(
	parameter int n_channels = 16
) (
	input logic clk,
	input logic reset,
	input logic tick,
	input logic busy,

	input dsp_core_pkg::sample_t sample_in,
	output dsp_core_pkg::sample_t sample_out,

	input logic [dsp_core_pkg::ch_addr_width - 1 : 0] src_a_addr,
	input logic [dsp_core_pkg::ch_addr_width - 1 : 0] src_b_addr,
	input logic [dsp_core_pkg::ch_addr_width - 1 : 0] src_c_addr,
	output dsp_core_pkg::sample_t ch_a,
	output dsp_core_pkg::sample_t ch_b,
	output dsp_core_pkg::sample_t ch_c,

	input logic result_valid,
	input dsp_core_pkg::sample_t result,
	input logic [dsp_core_pkg::ch_addr_width - 1 : 0] dest,
	output logic commit_done
);

	dsp_core_pkg::sample_t channels [n_channels];

	logic [dsp_core_pkg::ch_addr_width - 1 : 0] wb_dest;
	dsp_core_pkg::sample_t wb_data;
	logic sample_tick;

	assign sample_tick = tick & ~busy; // Ticks during a run are dropped.

	// Combinational operand reads.
	assign ch_a = channels[src_a_addr];
	assign ch_b = channels[src_b_addr];
	assign ch_c = channels[src_c_addr];

	//////////////////////////////
	// Result write-back.
	always_ff @(posedge clk) begin
		if (reset)
			commit_done <= 1'b0;
		else
			commit_done <= result_valid;
	end

	always_ff @(posedge clk) begin
		if (result_valid) begin
			wb_dest <= dest;
			wb_data <= result;
		end
	end

	//////////////////////////////
	// Channel file.
	always_ff @(posedge clk) begin
		if (reset) begin
			sample_out <= '0;
			for (int i = 0; i < n_channels; i++) begin
				channels[i] <= '0;
			end
		end else begin
			if (commit_done)
				channels[wb_dest] <= wb_data;
			if (sample_tick) begin
				channels[0] <= sample_in;
				sample_out <= channels[n_channels - 1]; // Value from the last run.
			end
		end
	end

endmodule

//--- hdl/madd_execute.sv
`timescale 1ns/1ps

module madd_execute (
	input logic clk,
	input logic reset,

	input logic issue_valid,
	input dsp_core_pkg::sample_t arg_a,
	input dsp_core_pkg::sample_t arg_b,
	input dsp_core_pkg::sample_t arg_c,
	input logic [dsp_core_pkg::shift_width - 1 : 0] shift,
	input logic sat_disable,
	input logic [dsp_core_pkg::ch_addr_width - 1 : 0] dest,

	output logic result_valid,
	output dsp_core_pkg::sample_t result,
	output logic [dsp_core_pkg::ch_addr_width - 1 : 0] dest_out
);

	dsp_core_pkg::wide_t product;
	dsp_core_pkg::wide_t shifted;
	dsp_core_pkg::wide_t sum;
	dsp_core_pkg::sample_t clamped;
	dsp_core_pkg::sample_t next_result;

	//////////////////////////////
	// Multiply, shift, add.
	assign product = dsp_core_pkg::wide_t'(arg_a) * dsp_core_pkg::wide_t'(arg_b);
	assign shifted = product >>> shift;
	assign sum = shifted + dsp_core_pkg::wide_t'(arg_c); // Cannot overflow 32 bits.

	always_comb begin
		if (sum > dsp_core_pkg::wide_t'(dsp_core_pkg::sample_max))
			clamped = dsp_core_pkg::sample_max;
		else if (sum < dsp_core_pkg::wide_t'(dsp_core_pkg::sample_min))
			clamped = dsp_core_pkg::sample_min;
		else
			clamped = sum[dsp_core_pkg::data_width - 1 : 0];
	end

	// Wrap instead of clamp.
	assign next_result = sat_disable ? sum[dsp_core_pkg::data_width - 1 : 0] : clamped;

	always_ff @(posedge clk) begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= issue_valid;
	end

	always_ff @(posedge clk) begin
		if (issue_valid) begin
			result <= next_result;
			dest_out <= dest;
		end
	end

endmodule

//--- hdl/block_decode.sv
`timescale 1ns/1ps

module block_decode #(
	parameter int n_blocks = 16,
	parameter int n_channels = 16
) (
	input logic clk,
	input logic reset,
	input logic tick,

	input logic instr_write,
	input logic [$clog2(n_blocks) - 1 : 0] instr_write_addr,
	input dsp_core_pkg::instr_t instr_write_data,
	input logic reg_write,
	input logic [$clog2(n_blocks) - 1 : 0] reg_write_block,
	input logic reg_write_sel,
	input dsp_core_pkg::sample_t reg_write_data,
	output logic [$clog2(n_blocks + 1) - 1 : 0] n_blocks_running,
	output logic busy,

	output logic [dsp_core_pkg::ch_addr_width - 1 : 0] src_a_addr,
	output logic [dsp_core_pkg::ch_addr_width - 1 : 0] src_b_addr,
	output logic [dsp_core_pkg::ch_addr_width - 1 : 0] src_c_addr,
	input dsp_core_pkg::sample_t ch_a,
	input dsp_core_pkg::sample_t ch_b,
	input dsp_core_pkg::sample_t ch_c,

	output logic issue_valid,
	output dsp_core_pkg::sample_t arg_a,
	output dsp_core_pkg::sample_t arg_b,
	output dsp_core_pkg::sample_t arg_c,
	output logic [dsp_core_pkg::shift_width - 1 : 0] shift,
	output logic sat_disable,
	output logic [dsp_core_pkg::ch_addr_width - 1 : 0] dest,
	input logic commit_done
);

	localparam int block_w = $clog2(n_blocks);
	localparam int count_w = $clog2(n_blocks + 1);

	typedef enum logic [1 : 0] {s_idle, s_fetch, s_wait} state_t;

	dsp_core_pkg::instr_t instrs [n_blocks];
	dsp_core_pkg::sample_t block_regs [n_blocks][2];

	state_t state;
	logic [block_w - 1 : 0] block;
	logic [count_w - 1 : 0] block_next;
	logic [count_w - 1 : 0] write_count;
	logic last_block;
	dsp_core_pkg::instr_t cur_instr;
	dsp_core_pkg::sample_t cur_reg0, cur_reg1;

	function automatic dsp_core_pkg::sample_t pick_operand(input logic use_reg,
		input logic reg_sel, input dsp_core_pkg::sample_t ch_value,
		input dsp_core_pkg::sample_t reg0, input dsp_core_pkg::sample_t reg1);
		if (!use_reg)
			return ch_value;
		return reg_sel ? reg1 : reg0;
	endfunction

	//////////////////////////////
	// Instruction store and block registers.
	assign write_count = instr_write_addr + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			n_blocks_running <= '0;
			for (int i = 0; i < n_blocks; i++) begin
				instrs[i] <= '0;
				block_regs[i][0] <= '0;
				block_regs[i][1] <= '0;
			end
		end else begin
			if (instr_write) begin
				instrs[instr_write_addr] <= instr_write_data;
				if (write_count >= n_blocks_running)
					n_blocks_running <= write_count;
			end
			if (reg_write)
				block_regs[reg_write_block][reg_write_sel] <= reg_write_data;
		end
	end

	//////////////////////////////
	// Operand fetch.
	assign cur_instr = instrs[block];
	assign cur_reg0 = block_regs[block][0];
	assign cur_reg1 = block_regs[block][1];
	assign src_a_addr = cur_instr[dsp_core_pkg::src_a_lsb +: dsp_core_pkg::ch_addr_width];
	assign src_b_addr = cur_instr[dsp_core_pkg::src_b_lsb +: dsp_core_pkg::ch_addr_width];
	assign src_c_addr = cur_instr[dsp_core_pkg::src_c_lsb +: dsp_core_pkg::ch_addr_width];

	assign block_next = block + 1'b1;
	assign last_block = block_next == n_blocks_running;
	assign busy = state != s_idle;

	always_ff @(posedge clk) begin
		if (cur_instr[dsp_core_pkg::instr_valid_bit] && state == s_fetch) begin
			arg_a <= pick_operand(cur_instr[dsp_core_pkg::src_a_reg_bit],
				cur_instr[dsp_core_pkg::src_a_lsb], ch_a, cur_reg0, cur_reg1);
			arg_b <= pick_operand(cur_instr[dsp_core_pkg::src_b_reg_bit],
				cur_instr[dsp_core_pkg::src_b_lsb], ch_b, cur_reg0, cur_reg1);
			arg_c <= pick_operand(cur_instr[dsp_core_pkg::src_c_reg_bit],
				cur_instr[dsp_core_pkg::src_c_lsb], ch_c, cur_reg0, cur_reg1);
			shift <= cur_instr[dsp_core_pkg::shift_lsb +: dsp_core_pkg::shift_width];
			sat_disable <= cur_instr[dsp_core_pkg::sat_disable_bit];
			dest <= cur_instr[dsp_core_pkg::dest_lsb +: dsp_core_pkg::ch_addr_width];
		end
	end

	//////////////////////////////
	// Block sequencer.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			block <= '0;
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= 1'b0;
			case (state)
				s_idle: begin
					if (tick && n_blocks_running != '0) begin
						block <= '0;
						state <= s_fetch;
					end
				end
				s_fetch: begin
					if (cur_instr[dsp_core_pkg::instr_valid_bit]) begin
						issue_valid <= 1'b1;
						state <= s_wait;
					end else if (last_block) begin
						state <= s_idle; // Nop as last block.
					end else begin
						block <= block + 1'b1;
					end
				end
				s_wait: begin
					if (commit_done) begin
						if (last_block) begin
							state <= s_idle;
						end else begin
							block <= block + 1'b1;
							state <= s_fetch;
						end
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

endmodule

//--- hdl/apb_command_port.sv
`timescale 1ns/1ps

module apb_command_port #(
	parameter int n_blocks = 16
) (
	input logic clk,
	input logic reset,

	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [dsp_core_pkg::paddr_width - 1 : 0] paddr,
	input logic [31 : 0] pwdata,
	output logic [31 : 0] prdata,
	output logic pready,
	output logic pslverr,

	output logic instr_write,
	output logic [$clog2(n_blocks) - 1 : 0] instr_write_addr,
	output dsp_core_pkg::instr_t instr_write_data,
	output logic reg_write,
	output logic [$clog2(n_blocks) - 1 : 0] reg_write_block,
	output logic reg_write_sel,
	output dsp_core_pkg::sample_t reg_write_data,
	input logic [$clog2(n_blocks + 1) - 1 : 0] n_blocks_running
);

	localparam int block_w = $clog2(n_blocks);

	logic access;
	logic [dsp_core_pkg::paddr_width - 1 : 0] instr_offset;
	logic [dsp_core_pkg::paddr_width - 1 : 0] reg_offset;
	logic in_instr, in_reg, is_status;

	assign access = psel & penable;

	// Offsets wrap below the base, so one compare covers the range.
	assign instr_offset = paddr - dsp_core_pkg::instr_base;
	assign reg_offset = paddr - dsp_core_pkg::reg_base;
	assign in_instr = instr_offset < 4 * n_blocks;
	assign in_reg = reg_offset < 8 * n_blocks;
	assign is_status = paddr == dsp_core_pkg::status_addr;

	assign pready = 1'b1; // Zero wait states.
	assign pslverr = access & (~(in_instr | in_reg | is_status) | (is_status & pwrite));

	//////////////////////////////
	// Write strobes.
	assign instr_write = access & pwrite & in_instr;
	assign instr_write_addr = instr_offset[2 +: block_w];
	assign instr_write_data = pwdata;

	assign reg_write = access & pwrite & in_reg;
	assign reg_write_block = reg_offset[3 +: block_w];
	assign reg_write_sel = reg_offset[2]; // Word address bit 0.
	assign reg_write_data = pwdata[dsp_core_pkg::data_width - 1 : 0];

	// Status captured in the setup phase.
	always_ff @(posedge clk) begin
		if (reset) begin
			prdata <= '0;
		end else if (psel && !penable && !pwrite) begin
			prdata <= is_status ? 32'(n_blocks_running) : '0;
		end
	end

endmodule

//--- hdl/dsp_core_pkg.sv
package dsp_core_pkg;

	localparam int data_width = 16;
	localparam int ch_addr_width = 4;
	localparam int shift_width = 5;
	localparam int paddr_width = 16;
	localparam int block_cycles = 4; // Fetch, operand, execute, write.

	typedef logic signed [data_width - 1 : 0] sample_t;
	typedef logic signed [2 * data_width - 1 : 0] wide_t;
	typedef logic [31 : 0] instr_t;

	//////////////////////////////
	// Instruction word layout.
	localparam int dest_lsb = 0;
	localparam int src_a_lsb = 4;
	localparam int src_b_lsb = 8;
	localparam int src_c_lsb = 12;
	localparam int src_a_reg_bit = 16;
	localparam int src_b_reg_bit = 17;
	localparam int src_c_reg_bit = 18;
	localparam int shift_lsb = 19;
	localparam int sat_disable_bit = 24;
	localparam int instr_valid_bit = 31; // Clear means nop.

	//////////////////////////////
	// APB byte address map.
	localparam logic [paddr_width - 1 : 0] instr_base = 16'h0000;
	localparam logic [paddr_width - 1 : 0] reg_base = 16'h1000;
	localparam logic [paddr_width - 1 : 0] status_addr = 16'h2000;

	// Clamp limits of the multiply-add.
	localparam sample_t sample_max = sample_t'(2 ** (data_width - 1) - 1);
	localparam sample_t sample_min = sample_t'(-(2 ** (data_width - 1)));

endpackage
